/* hw/flash_dev_pkg.sv */
`default_nettype none

package flash_dev_pkg;

	////////////////////////////////////////
	// AT49BV512 as wired on the board
	////////////////////////////////////////

	// One flash byte
	typedef logic [7:0] flash_data_t;
	// A15 pulled low and the upper lines tied together, so 10 lines are driven
	typedef logic [9:0] flash_adr_t;
	// Buffer address, also the word index while programming
	typedef logic [8:0] buf_adr_t;
	// Free-running phase count of one slow period pair
	typedef logic [4:0] phase_cnt_t;

	// Flash-side outputs, all strobes active low
	typedef struct packed {
		logic        ce_b;
		logic        oe_b;
		logic        we_b;
		logic        outen_b;
		flash_data_t dout;
		flash_adr_t  adr;
	} fm_bus_t;

	// Enables derived from the phase count
	typedef struct packed {
		logic slow_en;
		logic neg_en;
		logic wen;
	} slow_phase_t;

	localparam int BUF_DEPTH = 512;

	// JEDEC unlock addresses, board images of 5555 and 2AAA
	localparam flash_adr_t FM_UNLOCK_ADR1 = 10'h155;
	localparam flash_adr_t FM_UNLOCK_ADR2 = 10'h2AA;

	// JEDEC command bytes
	localparam flash_data_t FM_CMD_AA    = 8'hAA;
	localparam flash_data_t FM_CMD_55    = 8'h55;
	localparam flash_data_t FM_CMD_80    = 8'h80;
	localparam flash_data_t FM_CMD_A0    = 8'hA0;
	localparam flash_data_t FM_CMD_ERASE = 8'h10;

	////////////////////////////////////////
	// Sequence lengths and timing
	////////////////////////////////////////

	localparam int ERASE_CYCLES    = 6;
	localparam int PRG_HEAD_CYCLES = 3;
	localparam int PRG_WORDS       = 448;
	// Both counted in slow cycles
	localparam int HOLD_CYCLES     = 128;
	localparam int CE_RELEASE      = 16;

	// Programmed words live in the upper half of the board window
	localparam flash_adr_t PRG_ADR_BASE = 10'h200;

	// Phase points inside the 32-count period
	localparam phase_cnt_t PHASE_SLOW_A  = 5'd0;
	localparam phase_cnt_t PHASE_SLOW_B  = 5'd16;
	localparam phase_cnt_t PHASE_NEG_A   = 5'd8;
	localparam phase_cnt_t PHASE_NEG_B   = 5'd24;
	// Write pulse windows, bounds inclusive
	localparam phase_cnt_t PHASE_WEN_A_LO = 5'd2;
	localparam phase_cnt_t PHASE_WEN_A_HI = 5'd9;
	localparam phase_cnt_t PHASE_WEN_B_LO = 5'd18;
	localparam phase_cnt_t PHASE_WEN_B_HI = 5'd25;

endpackage

`default_nettype wire

/* hw/vme_cmd_pkg.sv */
`default_nettype none

package vme_cmd_pkg;

	typedef logic [9:0]  vme_cmd_t;
	typedef logic [15:0] vme_data_t;

	// Request fields from the bus master, stable while strobe is high
	typedef struct packed {
		logic      strobe;
		logic      write_b;
		logic      device;
		vme_cmd_t  command;
		vme_data_t indata;
	} vme_req_t;

	// Response back to the master, dtack_b is an active-low level
	typedef struct packed {
		logic      dtack_b;
		vme_data_t outdata;
	} vme_rsp_t;

	////////////////////////////////////////
	// Command codes
	////////////////////////////////////////

	localparam vme_cmd_t CMD_INIT       = 10'd0;
	localparam vme_cmd_t CMD_LOAD       = 10'd1;
	localparam vme_cmd_t CMD_PROGRAM    = 10'd2;
	localparam vme_cmd_t CMD_READ_RAM   = 10'd3;
	localparam vme_cmd_t CMD_ERASE      = 10'd5;
	localparam vme_cmd_t CMD_READ_FLASH = 10'd6;

	// One-cycle pulses first, then the two read levels
	typedef struct packed {
		logic init;
		logic erase;
		logic prog;
		logic load;
		logic read_adv;
		logic rd_ram;
		logic rd_flash;
	} cmd_pulses_t;

endpackage

`default_nettype wire

/* hw/slow_phase_gen.sv */
`default_nettype none

module slow_phase_gen (
	input  wire                        FASTCLK,
	input  wire                        le_rst,
	input  wire [4:0]                  clkcnt_i,
	output flash_dev_pkg::slow_phase_t phase_o
);

	import flash_dev_pkg::*;

	logic slow_hit;
	logic neg_hit;
	logic wen_hit;

	// Two slow periods per wrap of the 5-bit count
	assign slow_hit = (clkcnt_i == PHASE_SLOW_A) || (clkcnt_i == PHASE_SLOW_B);
	// Mid-period points, half a slow cycle later
	assign neg_hit = (clkcnt_i == PHASE_NEG_A) || (clkcnt_i == PHASE_NEG_B);

	// 8 counts wide, starting 2 counts after each slow point
	assign wen_hit = ((clkcnt_i >= PHASE_WEN_A_LO) && (clkcnt_i <= PHASE_WEN_A_HI)) ||
		((clkcnt_i >= PHASE_WEN_B_LO) && (clkcnt_i <= PHASE_WEN_B_HI));

	// Registered so every enable is a clean single FASTCLK cycle
	always_ff @(posedge FASTCLK or posedge le_rst) begin
		if (le_rst) begin
			phase_o <= '0;
		end else begin
			phase_o.slow_en <= slow_hit;
			phase_o.neg_en  <= neg_hit;
			phase_o.wen     <= wen_hit;
		end
	end

endmodule

`default_nettype wire

/* hw/vme_cmd_decode.sv */
`default_nettype none

module vme_cmd_decode (
	input  wire                        FASTCLK,
	input  wire                        le_rst,
	input  wire vme_cmd_pkg::vme_req_t req_i,
	input  wire flash_dev_pkg::slow_phase_t phase_i,
	input  wire flash_dev_pkg::flash_data_t buf_data_i,
	input  wire flash_dev_pkg::flash_data_t fm_din_i,
	input  wire                        busy_i,
	output vme_cmd_pkg::cmd_pulses_t   cmd_o,
	output vme_cmd_pkg::vme_rsp_t      rsp_o
);

	import vme_cmd_pkg::*;

	logic       is_init;
	logic       is_load;
	logic       is_prog;
	logic       is_erase;
	logic       is_rd_ram;
	logic       is_rd_flash;
	logic       stb_q;
	logic       stb_rise;
	logic       init_p;
	logic       erase_p;
	logic       prog_p;
	logic       ack_q;
	logic       ld_lvl;
	logic [2:0] ld_sh;
	logic       rd_ram_lvl;
	logic       rd_flash_lvl;
	logic       rd_lvl;
	logic       rd_q;
	logic [1:0] rd_sh;

	////////////////////////////////////////
	// Command match
	////////////////////////////////////////

	assign is_init     = req_i.device && (req_i.command == CMD_INIT);
	assign is_load     = req_i.device && (req_i.command == CMD_LOAD);
	assign is_prog     = req_i.device && (req_i.command == CMD_PROGRAM);
	assign is_erase    = req_i.device && (req_i.command == CMD_ERASE);
	assign is_rd_ram   = req_i.device && (req_i.command == CMD_READ_RAM);
	assign is_rd_flash = req_i.device && (req_i.command == CMD_READ_FLASH);

	assign stb_rise     = req_i.strobe && !stb_q;
	assign ld_lvl       = req_i.strobe && is_load;
	// Reads only count when the master is reading
	assign rd_ram_lvl   = req_i.strobe && req_i.write_b && is_rd_ram;
	assign rd_flash_lvl = req_i.strobe && req_i.write_b && is_rd_flash;
	assign rd_lvl       = rd_ram_lvl || rd_flash_lvl;

	always_ff @(posedge FASTCLK or posedge le_rst) begin
		if (le_rst) begin
			stb_q   <= 1'b0;
			init_p  <= 1'b0;
			erase_p <= 1'b0;
			prog_p  <= 1'b0;
			ack_q   <= 1'b0;
			rd_q    <= 1'b0;
			ld_sh   <= '0;
			rd_sh   <= '0;
		end else begin
			stb_q   <= req_i.strobe;
			// Leading-edge pulses, one cycle after strobe rises
			init_p  <= stb_rise && is_init;
			erase_p <= stb_rise && is_erase;
			prog_p  <= stb_rise && is_prog;
			// Acknowledge held until strobe drops, ignored commands too
			ack_q   <= req_i.strobe && (ack_q || init_p || erase_p || prog_p);
			rd_q    <= rd_lvl;
			// Load stages step on slow_en, first stage marks the write
			if (!ld_lvl) begin
				ld_sh <= '0;
			end else if (phase_i.slow_en) begin
				ld_sh <= {ld_sh[1:0], 1'b1};
			end
			// Read data settles one slow_en in, acknowledged at the next neg_en
			if (!rd_lvl) begin
				rd_sh <= '0;
			end else begin
				if (phase_i.slow_en) begin
					rd_sh[0] <= 1'b1;
				end
				if (phase_i.neg_en) begin
					rd_sh[1] <= rd_sh[0];
				end
			end
		end
	end

	assign cmd_o.init     = init_p;
	// Erase and program are dropped while a sequence runs
	assign cmd_o.erase    = erase_p && !busy_i;
	assign cmd_o.prog     = prog_p && !busy_i;
	// Load is a single cycle lined up with slow_en
	assign cmd_o.load     = ld_lvl && phase_i.slow_en && !ld_sh[0];
	// Falling strobe of a read moves to the next word
	assign cmd_o.read_adv = rd_q && !rd_lvl;
	assign cmd_o.rd_ram   = rd_ram_lvl;
	assign cmd_o.rd_flash = rd_flash_lvl;

	assign rsp_o.dtack_b = !(ack_q || (ld_lvl && ld_sh[2]) || (rd_lvl && rd_sh[1]));

	// Upper byte always zero
	always_comb begin
		rsp_o.outdata = '0;
		if (rd_ram_lvl) begin
			rsp_o.outdata[7:0] = buf_data_i;
		end else if (rd_flash_lvl) begin
			rsp_o.outdata[7:0] = fm_din_i;
		end
	end

endmodule

`default_nettype wire

/* hw/prog_buffer.sv */
`default_nettype none

module prog_buffer (
	input  wire                        FASTCLK,
	input  wire                        le_rst,
	input  wire flash_dev_pkg::slow_phase_t phase_i,
	input  wire vme_cmd_pkg::cmd_pulses_t   cmd_i,
	input  wire flash_dev_pkg::flash_data_t wdata_i,
	input  wire flash_dev_pkg::buf_adr_t    radr_i,
	output flash_dev_pkg::flash_data_t      rdata_o
);

	import flash_dev_pkg::*;

	flash_data_t mem [BUF_DEPTH];
	buf_adr_t    wadr;
	logic        wr_en;

	// Load pulse already sits on slow_en
	assign wr_en = cmd_i.load && phase_i.slow_en;

	// Load address, steps after each write
	always_ff @(posedge FASTCLK or posedge le_rst) begin
		if (le_rst) begin
			wadr <= '0;
		end else if (cmd_i.init) begin
			wadr <= '0;
		end else if (wr_en) begin
			wadr <= wadr + 1'b1;
		end
	end

	////////////////////////////////////////
	// Dual-port RAM, VME writes, sequencer reads
	////////////////////////////////////////

	always_ff @(posedge FASTCLK) begin
		if (wr_en) begin
			mem[wadr] <= wdata_i;
		end
		// Read port runs at the slow rate
		if (phase_i.slow_en) begin
			rdata_o <= mem[radr_i];
		end
	end

endmodule

`default_nettype wire

/* hw/flash_sequencer.sv */
`default_nettype none

module flash_sequencer (
	input  wire                        FASTCLK,
	input  wire                        le_rst,
	input  wire flash_dev_pkg::slow_phase_t phase_i,
	input  wire vme_cmd_pkg::cmd_pulses_t   cmd_i,
	input  wire flash_dev_pkg::flash_data_t buf_data_i,
	output flash_dev_pkg::buf_adr_t    radr_o,
	output logic                       busy_o,
	output flash_dev_pkg::fm_bus_t     fm_o
);

	import flash_dev_pkg::*;

	logic                              erase_pend;
	logic [ERASE_CYCLES-1:0]           ersh;
	logic                              erase_end;
	logic                              prg_pend;
	logic [PRG_HEAD_CYCLES:0]          phd;
	logic                              hold_run;
	logic [$clog2(HOLD_CYCLES)-1:0]    hold_cnt;
	logic                              hold_end;
	logic                              last_word;
	logic                              bgn_word;
	logic                              ce_wr;
	logic                              active;
	buf_adr_t                          wcnt;
	logic                              wr_cycle;
	logic                              rd_cycle;
	flash_adr_t                        word_adr;

	assign erase_end = ersh[ERASE_CYCLES-1];
	assign hold_end  = hold_run && (int'(hold_cnt) == HOLD_CYCLES - 1);
	// All words written once the index passes the last one
	assign last_word = (int'(wcnt) == PRG_WORDS);
	// First word from the pending start, later ones when the hold runs out
	assign bgn_word  = prg_pend || (hold_end && !last_word);

	////////////////////////////////////////
	// Erase and program sequencers
	////////////////////////////////////////

	always_ff @(posedge FASTCLK or posedge le_rst) begin
		if (le_rst) begin
			erase_pend <= 1'b0;
			prg_pend   <= 1'b0;
			ersh       <= '0;
			phd        <= '0;
			hold_run   <= 1'b0;
			hold_cnt   <= '0;
			ce_wr      <= 1'b0;
			active     <= 1'b0;
			wcnt       <= '0;
		end else if (cmd_i.init) begin
			// Init aborts whatever is running
			erase_pend <= 1'b0;
			prg_pend   <= 1'b0;
			ersh       <= '0;
			phd        <= '0;
			hold_run   <= 1'b0;
			hold_cnt   <= '0;
			ce_wr      <= 1'b0;
			active     <= 1'b0;
			wcnt       <= '0;
		end else begin
			// Starts wait for the next slow_en
			if (cmd_i.erase) begin
				erase_pend <= 1'b1;
			end else if (phase_i.slow_en) begin
				erase_pend <= 1'b0;
			end
			if (cmd_i.prog) begin
				prg_pend <= 1'b1;
			end else if (phase_i.slow_en) begin
				prg_pend <= 1'b0;
			end

			// Output enable covers the whole erase or program run
			if (cmd_i.erase || cmd_i.prog) begin
				active <= 1'b1;
			end else if (phase_i.slow_en && (erase_end || (hold_end && last_word))) begin
				active <= 1'b0;
			end

			// Word index shared by programming and both readbacks
			if (cmd_i.prog) begin
				wcnt <= '0;
			end else if (cmd_i.read_adv || (phase_i.slow_en && phd[PRG_HEAD_CYCLES])) begin
				wcnt <= wcnt + 1'b1;
			end

			if (phase_i.slow_en) begin
				// One-hot stage shifts
				ersh <= {ersh[ERASE_CYCLES-2:0], erase_pend};
				phd  <= {phd[PRG_HEAD_CYCLES-1:0], bgn_word};

				// Hold timer starts after the data stage
				if (phd[PRG_HEAD_CYCLES]) begin
					hold_run <= 1'b1;
					hold_cnt <= '0;
				end else if (hold_end) begin
					hold_run <= 1'b0;
					hold_cnt <= '0;
				end else if (hold_run) begin
					hold_cnt <= hold_cnt + 1'b1;
				end

				// Chip enable for writes, released early in the hold
				if (erase_pend || bgn_word) begin
					ce_wr <= 1'b1;
				end else if (erase_end || (hold_run && (int'(hold_cnt) == CE_RELEASE - 1))) begin
					ce_wr <= 1'b0;
				end
			end
		end
	end

	assign busy_o   = active;
	assign radr_o   = wcnt;
	assign wr_cycle = (|ersh) || (|phd);
	// Direct reads stay off the bus during a write run
	assign rd_cycle = cmd_i.rd_flash && !active;
	assign word_adr = PRG_ADR_BASE + flash_adr_t'(wcnt);

	////////////////////////////////////////
	// Flash bus multiplexer
	////////////////////////////////////////

	always_comb begin
		fm_o.ce_b    = !(ce_wr || rd_cycle);
		fm_o.oe_b    = !rd_cycle;
		// Write pulse shaped by the phase window
		fm_o.we_b    = !(phase_i.wen && wr_cycle);
		fm_o.outen_b = !active;
		fm_o.dout    = '0;
		fm_o.adr     = '0;
		// Erase: AA 55 80 AA 55 10
		if (ersh[0] || ersh[3]) begin
			fm_o.adr  = FM_UNLOCK_ADR1;
			fm_o.dout = FM_CMD_AA;
		end else if (ersh[1] || ersh[4]) begin
			fm_o.adr  = FM_UNLOCK_ADR2;
			fm_o.dout = FM_CMD_55;
		end else if (ersh[2]) begin
			fm_o.adr  = FM_UNLOCK_ADR1;
			fm_o.dout = FM_CMD_80;
		end else if (ersh[5]) begin
			fm_o.adr  = FM_UNLOCK_ADR1;
			fm_o.dout = FM_CMD_ERASE;
		// Program header AA 55 A0
		end else if (phd[0]) begin
			fm_o.adr  = FM_UNLOCK_ADR1;
			fm_o.dout = FM_CMD_AA;
		end else if (phd[1]) begin
			fm_o.adr  = FM_UNLOCK_ADR2;
			fm_o.dout = FM_CMD_55;
		end else if (phd[2]) begin
			fm_o.adr  = FM_UNLOCK_ADR1;
			fm_o.dout = FM_CMD_A0;
		end else if (phd[PRG_HEAD_CYCLES]) begin
			fm_o.adr  = word_adr;
			fm_o.dout = buf_data_i;
		end else if (rd_cycle) begin
			fm_o.adr = word_adr;
		end
	end

endmodule

`default_nettype wire

/* hw/flash_prog_top.sv */
`default_nettype none

module flash_prog_top (
	input  wire                        FASTCLK,
	input  wire                        le_rst,
	input  wire [4:0]                  clkcnt_i,
	input  wire vme_cmd_pkg::vme_req_t vme_req_i,
	input  wire flash_dev_pkg::flash_data_t fm_din_i,
	output vme_cmd_pkg::vme_rsp_t      vme_rsp_o,
	output flash_dev_pkg::fm_bus_t     fm_bus_o
);

	import flash_dev_pkg::*;
	import vme_cmd_pkg::*;

	slow_phase_t phase;
	cmd_pulses_t cmd;
	flash_data_t buf_data;
	buf_adr_t    radr;
	logic        busy;

	// Slow-clock enables for everything below
	slow_phase_gen u_phase (
		.FASTCLK  (FASTCLK),
		.le_rst   (le_rst),
		.clkcnt_i (clkcnt_i),
		.phase_o  (phase)
	);

	vme_cmd_decode u_decode (
		.FASTCLK    (FASTCLK),
		.le_rst     (le_rst),
		.req_i      (vme_req_i),
		.phase_i    (phase),
		.buf_data_i (buf_data),
		.fm_din_i   (fm_din_i),
		.busy_i     (busy),
		.cmd_o      (cmd),
		.rsp_o      (vme_rsp_o)
	);

	// Buffer bytes come from the low data byte
	prog_buffer u_buffer (
		.FASTCLK (FASTCLK),
		.le_rst  (le_rst),
		.phase_i (phase),
		.cmd_i   (cmd),
		.wdata_i (vme_req_i.indata[7:0]),
		.radr_i  (radr),
		.rdata_o (buf_data)
	);

	flash_sequencer u_seq (
		.FASTCLK    (FASTCLK),
		.le_rst     (le_rst),
		.phase_i    (phase),
		.cmd_i      (cmd),
		.buf_data_i (buf_data),
		.radr_o     (radr),
		.busy_o     (busy),
		.fm_o       (fm_bus_o)
	);

endmodule

`default_nettype wire

/* verification/flash_prog_checker.sv */
`default_nettype none

module flash_prog_checker (
	input wire                         FASTCLK,
	input wire                         le_rst,
	input wire flash_dev_pkg::fm_bus_t fm_i
);

	// Number of failed assertions
	int unsigned fail_cnt = 0;

	////////////////////////////////////////
	// Flash bus protocol
	////////////////////////////////////////

	// No write into a chip that drives its outputs
	we_oe_excl: assert property (@(posedge FASTCLK) disable iff (le_rst)
		!(!fm_i.we_b && !fm_i.oe_b))
		else begin
			$error("flash we_b and oe_b are low together");
			fail_cnt++;
		end

	// Write pulses only inside a chip enable
	we_in_ce: assert property (@(posedge FASTCLK) disable iff (le_rst)
		!fm_i.we_b |-> !fm_i.ce_b)
		else begin
			$error("flash we_b is low while ce_b is high");
			fail_cnt++;
		end

	// Board drivers on while writing
	we_in_outen: assert property (@(posedge FASTCLK) disable iff (le_rst)
		!fm_i.we_b |-> !fm_i.outen_b)
		else begin
			$error("flash we_b is low while outen_b is high");
			fail_cnt++;
		end

endmodule

bind flash_sequencer flash_prog_checker fm_chk (
	.FASTCLK (FASTCLK),
	.le_rst  (le_rst),
	.fm_i    (fm_o)
);

`default_nettype wire

/* verification/flash_prog_tb.sv */
`default_nettype none

module flash_prog_tb;

	import flash_dev_pkg::*;
	import vme_cmd_pkg::*;

	localparam int DTACK_TIMEOUT = 256;
	// Full program run in FASTCLK cycles with margin
	localparam int OUTEN_TIMEOUT = PRG_WORDS * (PRG_HEAD_CYCLES + HOLD_CYCLES + 3) * 32;
	localparam int CASE_WORDS    = 64;
	localparam int FLASH_BYTES   = 1024;

	logic        FASTCLK;
	logic        le_rst;
	logic [4:0]  clkcnt;
	vme_req_t    vme_req;
	vme_rsp_t    vme_rsp;
	flash_data_t fm_din;
	fm_bus_t     fm_bus;

	logic [7:0]  case_mem [CASE_WORDS];
	flash_data_t exp_buf [PRG_WORDS];
	flash_data_t flash_mem [FLASH_BYTES];
	// Writes seen on the flash bus in order
	flash_adr_t  cap_adr [$];
	flash_data_t cap_dat [$];
	flash_adr_t  wr_adr;
	flash_data_t wr_dat;
	logic        we_q;
	logic        prg_next;
	integer      seed;
	int          load_idx;
	int          mismatches;
	int          timeouts;
	int          other_errs;
	int          total_errs;
	logic        aborted;

	flash_prog_top uut (
		.FASTCLK   (FASTCLK),
		.le_rst    (le_rst),
		.clkcnt_i  (clkcnt),
		.vme_req_i (vme_req),
		.fm_din_i  (fm_din),
		.vme_rsp_o (vme_rsp),
		.fm_bus_o  (fm_bus)
	);

	always #10 FASTCLK = ~FASTCLK;

	// Board phase count stepping once per FASTCLK
	always begin
		@(posedge FASTCLK);
		#2;
		clkcnt = clkcnt + 1'b1;
	end

	////////////////////////////////////////
	// Flash model
	////////////////////////////////////////

	// Answers while selected and output-enabled
	assign fm_din = (!fm_bus.ce_b && !fm_bus.oe_b) ? flash_mem[fm_bus.adr] : 8'h00;

	always @(negedge FASTCLK) begin
		if (fm_bus.we_b === 1'b0) begin
			wr_adr = fm_bus.adr;
			wr_dat = fm_bus.dout;
		end else if (we_q === 1'b0) begin
			// Rising we_b closes a write
			cap_adr.push_back(wr_adr);
			cap_dat.push_back(wr_dat);
			if (prg_next) begin
				flash_mem[wr_adr] = wr_dat;
				prg_next = 1'b0;
			end else if (wr_adr == FM_UNLOCK_ADR1 && wr_dat == FM_CMD_A0) begin
				prg_next = 1'b1;
			end else if (wr_adr == FM_UNLOCK_ADR1 && wr_dat == FM_CMD_ERASE) begin
				for (int a = 0; a < FLASH_BYTES; a++) begin
					flash_mem[a] = 8'hFF;
				end
			end
		end
		we_q = fm_bus.we_b;
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_byte(input string name, input flash_data_t got, input flash_data_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_adr(input string name, input flash_adr_t got, input flash_adr_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_word(input string name, input vme_data_t got, input vme_data_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	////////////////////////////////////////
	// Waits and bus cycles
	////////////////////////////////////////

	task automatic wait_dtack(input logic level, input string what);
		int n;
		n = 0;
		@(negedge FASTCLK);
		while (vme_rsp.dtack_b !== level && n < DTACK_TIMEOUT) begin
			@(negedge FASTCLK);
			n++;
		end
		if (vme_rsp.dtack_b !== level) begin
			$display("Timeout: dtack_b never went to %0b during %s", level, what);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	// End of an erase or program run
	task automatic wait_outen();
		int n;
		n = 0;
		@(negedge FASTCLK);
		while (fm_bus.outen_b !== 1'b1 && n < OUTEN_TIMEOUT) begin
			@(negedge FASTCLK);
			n++;
		end
		if (fm_bus.outen_b !== 1'b1) begin
			$display("Timeout: outen_b stayed low after the write sequence");
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	// One VME cycle with data and flash address taken while dtack_b is low
	task automatic bus_cycle(input vme_cmd_t cmd, input logic rd, input flash_data_t wbyte,
			output vme_data_t rdata, output flash_adr_t radr);
		@(posedge FASTCLK);
		#2;
		vme_req.device  = 1'b1;
		vme_req.write_b = rd;
		vme_req.command = cmd;
		vme_req.indata  = {8'h00, wbyte};
		vme_req.strobe  = 1'b1;
		wait_dtack(1'b0, $sformatf("command %0d", cmd));
		rdata = vme_rsp.outdata;
		radr  = fm_bus.adr;
		@(posedge FASTCLK);
		#2;
		vme_req.strobe = 1'b0;
		if (!aborted) begin
			wait_dtack(1'b1, $sformatf("release of command %0d", cmd));
		end
	endtask

	task automatic load_byte(input flash_data_t b);
		vme_data_t  rd;
		flash_adr_t ra;
		bus_cycle(CMD_LOAD, 1'b0, b, rd, ra);
		if (load_idx < PRG_WORDS) begin
			exp_buf[load_idx] = b;
		end
		load_idx++;
	endtask

	// Word sequence from index 0 after an init
	task automatic read_back(input logic from_flash);
		vme_data_t  rd;
		flash_adr_t ra;
		for (int i = 0; i < PRG_WORDS && !aborted; i++) begin
			if (from_flash) begin
				bus_cycle(CMD_READ_FLASH, 1'b1, 8'h00, rd, ra);
				if (!aborted) begin
					check_adr($sformatf("fm_bus_o.adr read %0d", i), ra,
						PRG_ADR_BASE + flash_adr_t'(i));
				end
			end else begin
				bus_cycle(CMD_READ_RAM, 1'b1, 8'h00, rd, ra);
			end
			if (!aborted) begin
				check_word($sformatf("vme_rsp_o.outdata read %0d", i), rd, {8'h00, exp_buf[i]});
			end
		end
	endtask

	task automatic run_write_seq(input vme_cmd_t cmd);
		vme_data_t  rd;
		flash_adr_t ra;
		cap_adr.delete();
		cap_dat.delete();
		bus_cycle(cmd, 1'b0, 8'h00, rd, ra);
		if (!aborted) begin
			wait_outen();
		end
	endtask

	// JEDEC chip erase AA 55 80 AA 55 10
	task automatic check_erase();
		flash_adr_t  ea [ERASE_CYCLES];
		flash_data_t ed [ERASE_CYCLES];
		ea = '{FM_UNLOCK_ADR1, FM_UNLOCK_ADR2, FM_UNLOCK_ADR1,
			FM_UNLOCK_ADR1, FM_UNLOCK_ADR2, FM_UNLOCK_ADR1};
		ed = '{FM_CMD_AA, FM_CMD_55, FM_CMD_80, FM_CMD_AA, FM_CMD_55, FM_CMD_ERASE};
		if (cap_adr.size() != ERASE_CYCLES) begin
			$display("Erase made %0d flash writes instead of %0d", cap_adr.size(), ERASE_CYCLES);
			other_errs++;
		end
		for (int k = 0; k < ERASE_CYCLES && k < cap_adr.size(); k++) begin
			check_adr($sformatf("erase write %0d adr", k), cap_adr[k], ea[k]);
			check_byte($sformatf("erase write %0d dout", k), cap_dat[k], ed[k]);
		end
	endtask

	// Unlock header then the buffer byte for each word
	task automatic check_program();
		flash_adr_t  ha [PRG_HEAD_CYCLES];
		flash_data_t hd [PRG_HEAD_CYCLES];
		int          k;
		ha = '{FM_UNLOCK_ADR1, FM_UNLOCK_ADR2, FM_UNLOCK_ADR1};
		hd = '{FM_CMD_AA, FM_CMD_55, FM_CMD_A0};
		if (cap_adr.size() != PRG_WORDS * (PRG_HEAD_CYCLES + 1)) begin
			$display("Programming made %0d flash writes instead of %0d", cap_adr.size(),
				PRG_WORDS * (PRG_HEAD_CYCLES + 1));
			other_errs++;
		end
		for (int i = 0; i < PRG_WORDS; i++) begin
			for (int j = 0; j <= PRG_HEAD_CYCLES; j++) begin
				k = i * (PRG_HEAD_CYCLES + 1) + j;
				if (k < cap_adr.size() && j < PRG_HEAD_CYCLES) begin
					check_adr($sformatf("word %0d header %0d adr", i, j), cap_adr[k], ha[j]);
					check_byte($sformatf("word %0d header %0d dout", i, j), cap_dat[k], hd[j]);
				end else if (k < cap_adr.size()) begin
					check_adr($sformatf("word %0d data adr", i), cap_adr[k],
						PRG_ADR_BASE + flash_adr_t'(i));
					check_byte($sformatf("word %0d data dout", i), cap_dat[k], exp_buf[i]);
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int         step;
		logic [7:0] op;
		logic [7:0] val;
		integer     rnd;
		vme_data_t  rd;
		flash_adr_t ra;
		FASTCLK    = 1'b0;
		le_rst     = 1'b1;
		clkcnt     = '0;
		vme_req    = '0;
		seed       = 19;
		we_q       = 1'b1;
		prg_next   = 1'b0;
		wr_adr     = '0;
		wr_dat     = '0;
		load_idx   = 0;
		mismatches = 0;
		timeouts   = 0;
		other_errs = 0;
		aborted    = 1'b0;
		// Power-up pattern depends on every address bit
		for (int a = 0; a < FLASH_BYTES; a++) begin
			flash_mem[a] = 8'((a * 37) ^ (a >> 3));
		end
		for (int w = 0; w < CASE_WORDS; w++) begin
			case_mem[w] = 8'hFF;
		end
		for (int i = 0; i < PRG_WORDS; i++) begin
			exp_buf[i] = '0;
		end
		$readmemh("verification/flash_prog_cases.txt", case_mem);

		repeat (10) @(posedge FASTCLK);
		#2;
		le_rst = 1'b0;
		@(negedge FASTCLK);
		// Idle state after reset
		check_bit("vme_rsp_o.dtack_b", vme_rsp.dtack_b, 1'b1);
		check_word("vme_rsp_o.outdata", vme_rsp.outdata, 16'h0000);
		check_bit("fm_bus_o.ce_b", fm_bus.ce_b, 1'b1);
		check_bit("fm_bus_o.oe_b", fm_bus.oe_b, 1'b1);
		check_bit("fm_bus_o.we_b", fm_bus.we_b, 1'b1);
		check_bit("fm_bus_o.outen_b", fm_bus.outen_b, 1'b1);

		step = 0;
		while (!aborted && step < CASE_WORDS / 2 && case_mem[2 * step] != 8'hFF) begin
			op  = case_mem[2 * step];
			val = case_mem[2 * step + 1];
			case (op)
				8'h00: begin
					bus_cycle(CMD_INIT, 1'b0, 8'h00, rd, ra);
					load_idx = 0;
				end
				8'h01: load_byte(val);
				8'h0F: begin
					while (!aborted && load_idx < PRG_WORDS) begin
						rnd = $random(seed);
						load_byte(rnd[7:0]);
					end
				end
				8'h03: read_back(1'b0);
				8'h05: begin
					run_write_seq(CMD_ERASE);
					if (!aborted) begin
						check_erase();
					end
				end
				8'h02: begin
					run_write_seq(CMD_PROGRAM);
					if (!aborted) begin
						check_program();
					end
				end
				8'h06: read_back(1'b1);
				default: begin
					$display("Unknown operation %h in the cases file", op);
					other_errs++;
				end
			endcase
			step++;
		end
		if (step == 0) begin
			$display("No steps were read from the cases file");
			other_errs++;
		end

		repeat (4) @(posedge FASTCLK);
		total_errs = mismatches + timeouts + other_errs + int'(uut.u_seq.fm_chk.fail_cnt);
		$display("Errors: %0d mismatches, %0d timeouts, %0d other, %0d assertion failures",
			mismatches, timeouts, other_errs, uut.u_seq.fm_chk.fail_cnt);
		if (total_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/flash_prog_cases.txt */
// Columns: operation, byte value. 00 init, 01 load byte, 0F random loads up to 448
// 03 read buffer, 05 erase, 02 program, 06 read flash, FF end of list
00 00
01 A5
01 5A
01 00
01 FF
01 3C
01 C3
01 81
01 7E
0F 00
00 00
03 00
05 00
02 00
00 00
06 00
FF 00

/* src.f */
hw/flash_dev_pkg.sv
hw/vme_cmd_pkg.sv
hw/slow_phase_gen.sv
hw/vme_cmd_decode.sv
hw/prog_buffer.sv
hw/flash_sequencer.sv
hw/flash_prog_top.sv
verification/flash_prog_checker.sv
verification/flash_prog_tb.sv

/* Bender.yml */
package:
  name: flash_prog

sources:
  - files:
      - hw/flash_dev_pkg.sv
      - hw/vme_cmd_pkg.sv
      - hw/slow_phase_gen.sv
      - hw/vme_cmd_decode.sv
      - hw/prog_buffer.sv
      - hw/flash_sequencer.sv
      - hw/flash_prog_top.sv
  - target: test
    files:
      - verification/flash_prog_checker.sv
      - verification/flash_prog_tb.sv
